/* design/seg_display_pkg.sv */
`default_nettype none

package seg_display_pkg;

    // display geometry.
    localparam int NUM_DIGITS = 8;
    localparam int DIGIT_W    = 3;  // index into the eight digits.

    // one ascii code per digit.
    localparam int CHAR_W = 8;

    // segments a..g in bits 0..6, decimal point in bit 7.
    localparam int SEG_W = 8;

    // scan pacing, kept tiny for simulation.
    localparam int DWELL_CYCLES = 4;
    localparam int DWELL_W      = $clog2(DWELL_CYCLES);

    // common-anode board, a low level lights a segment or a digit.
    localparam logic LED_ON = 1'b0;

    // buffer contents after reset.
    localparam logic [CHAR_W-1:0] CHAR_SPACE = 8'h20;

endpackage

`default_nettype wire

/* design/text_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module text_buffer (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire                                    wr_en,
    input  wire  [seg_display_pkg::DIGIT_W-1:0]    wr_addr,
    input  wire  [seg_display_pkg::CHAR_W-1:0]     wr_char,
    input  wire                                    wr_point,
    output logic [seg_display_pkg::NUM_DIGITS*seg_display_pkg::CHAR_W-1:0] chars,
    output logic [seg_display_pkg::NUM_DIGITS-1:0] points
);

    // one-hot write select, all zero when idle.
    logic [seg_display_pkg::NUM_DIGITS-1:0] wr_hit;

    always_comb begin
        wr_hit = '0;
        if (wr_en) begin
            wr_hit[wr_addr] = 1'b1;
        end
    end

    // digit d lives in chars[d*8 +: 8] and points[d].
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chars  <= {seg_display_pkg::NUM_DIGITS{seg_display_pkg::CHAR_SPACE}};
            points <= '0;  // blank text, no points.
        end else begin
            for (int d = 0; d < seg_display_pkg::NUM_DIGITS; d++) begin
                if (wr_hit[d]) begin
                    chars[d*seg_display_pkg::CHAR_W +: seg_display_pkg::CHAR_W] <= wr_char;
                    points[d] <= wr_point;
                end
            end
        end
    end

    // an unknown address would silently corrupt a random digit.
    wr_addr_known_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_addr)
    ) else $error("text_buffer: write with unknown address %b", wr_addr);

endmodule

`default_nettype wire

/* design/glyph_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_decoder (
    input  wire  [seg_display_pkg::NUM_DIGITS*seg_display_pkg::CHAR_W-1:0] chars,
    input  wire  [seg_display_pkg::NUM_DIGITS-1:0]                         points,
    output logic [seg_display_pkg::NUM_DIGITS*seg_display_pkg::SEG_W-1:0]  patterns
);

    // segment bits g..a, active high.
    function automatic logic [seg_display_pkg::SEG_W-2:0] glyph(
        input logic [seg_display_pkg::CHAR_W-1:0] c
    );
        case (c)
            "0":     glyph = 7'h3f;
            "1":     glyph = 7'h06;
            "2":     glyph = 7'h5b;
            "3":     glyph = 7'h4f;
            "4":     glyph = 7'h66;
            "5":     glyph = 7'h6d;
            "6":     glyph = 7'h7d;
            "7":     glyph = 7'h07;
            "8":     glyph = 7'h7f;
            "9":     glyph = 7'h6f;
            "A", "a": glyph = 7'h77;
            "B", "b": glyph = 7'h7c;
            "C", "c": glyph = 7'h39;
            "D", "d": glyph = 7'h5e;
            "E", "e": glyph = 7'h79;
            "F", "f": glyph = 7'h71;
            "G", "g": glyph = 7'h3d;
            "H", "h": glyph = 7'h76;
            "I", "i": glyph = 7'h0f;
            "J", "j": glyph = 7'h0e;
            "K", "k": glyph = 7'h75;
            "L", "l": glyph = 7'h38;
            "M", "m": glyph = 7'h37;
            "N", "n": glyph = 7'h54;
            "O", "o": glyph = 7'h5c;
            "P", "p": glyph = 7'h73;
            "Q", "q": glyph = 7'h67;
            "R", "r": glyph = 7'h31;
            "S", "s": glyph = 7'h49;
            "T", "t": glyph = 7'h78;
            "U", "u": glyph = 7'h3e;
            "V", "v": glyph = 7'h1c;
            "W", "w": glyph = 7'h7e;
            "X", "x": glyph = 7'h64;
            "Y", "y": glyph = 7'h6e;
            "Z", "z": glyph = 7'h59;
            " ":     glyph = 7'h00;
            "-":     glyph = 7'h40;
            "_":     glyph = 7'h08;
            "=":     glyph = 7'h48;
            "+":     glyph = 7'h5c;  // same shape as o.
            "(":     glyph = 7'h39;
            ")":     glyph = 7'h0f;
            default: glyph = 7'h00;  // anything else stays dark.
        endcase
    endfunction

    // all digits decode in parallel, the scan side picks one.
    always_comb begin
        for (int i = 0; i < seg_display_pkg::NUM_DIGITS; i++) begin
            patterns[i*seg_display_pkg::SEG_W +: seg_display_pkg::SEG_W] = {
                points[i],
                glyph(chars[i*seg_display_pkg::CHAR_W +: seg_display_pkg::CHAR_W])
            };
        end
    end

endmodule

`default_nettype wire

/* design/scan_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_mux (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire                                    display_en,
    input  wire  [seg_display_pkg::NUM_DIGITS*seg_display_pkg::SEG_W-1:0] patterns,
    output logic [seg_display_pkg::SEG_W-1:0]      seg,
    output logic [seg_display_pkg::NUM_DIGITS-1:0] sel
);

    logic                                   scan_live;  // set on the first edge after reset.
    logic [seg_display_pkg::DWELL_W-1:0]    dwell_cnt;
    logic [seg_display_pkg::DIGIT_W-1:0]    digit_idx;
    logic [seg_display_pkg::SEG_W-1:0]      cur_pattern;
    logic [seg_display_pkg::NUM_DIGITS-1:0] cur_onehot;

    // dwell counter paces the digit index.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_live <= 1'b0;
            dwell_cnt <= '0;
            digit_idx <= '0;
        end else begin
            scan_live <= 1'b1;
            if (scan_live) begin
                if (int'(dwell_cnt) == seg_display_pkg::DWELL_CYCLES - 1) begin
                    dwell_cnt <= '0;
                    if (int'(digit_idx) == seg_display_pkg::NUM_DIGITS - 1) begin
                        digit_idx <= '0;
                    end else begin
                        digit_idx <= digit_idx + 1'b1;
                    end
                end else begin
                    dwell_cnt <= dwell_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        cur_pattern = patterns[digit_idx*seg_display_pkg::SEG_W +: seg_display_pkg::SEG_W];
        cur_onehot = '0;
        cur_onehot[digit_idx] = 1'b1;
    end

    // xor with the off level maps active-high to board polarity.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seg <= {seg_display_pkg::SEG_W{~seg_display_pkg::LED_ON}};
            sel <= {seg_display_pkg::NUM_DIGITS{~seg_display_pkg::LED_ON}};
        end else if (!scan_live || !display_en) begin
            seg <= {seg_display_pkg::SEG_W{~seg_display_pkg::LED_ON}};  // dark.
            sel <= {seg_display_pkg::NUM_DIGITS{~seg_display_pkg::LED_ON}};
        end else begin
            seg <= cur_pattern ^ {seg_display_pkg::SEG_W{~seg_display_pkg::LED_ON}};
            sel <= cur_onehot ^ {seg_display_pkg::NUM_DIGITS{~seg_display_pkg::LED_ON}};
        end
    end

    // pattern of the digit whose select line is low.
    function automatic logic [seg_display_pkg::SEG_W-1:0] lit_pattern(
        input logic [seg_display_pkg::NUM_DIGITS*seg_display_pkg::SEG_W-1:0] pats,
        input logic [seg_display_pkg::NUM_DIGITS-1:0]                        lines
    );
        lit_pattern = '0;
        for (int i = 0; i < seg_display_pkg::NUM_DIGITS; i++) begin
            if (lines[i] == seg_display_pkg::LED_ON) begin
                lit_pattern = pats[i*seg_display_pkg::SEG_W +: seg_display_pkg::SEG_W];
            end
        end
    endfunction

    // two lit digits would ghost one glyph onto another.
    sel_one_cold_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(~sel)
    ) else $error("scan_mux: more than one digit selected, sel=%b", sel);

    // the lit pattern belongs to the digit that was current one cycle back.
    seg_matches_digit_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (sel != '1) |-> (seg == ~lit_pattern($past(patterns), sel))
    ) else $error("scan_mux: seg %h does not follow selected digit", seg);

endmodule

`default_nettype wire

/* design/seg_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_display_top (
    input  wire                                    clk,
    input  wire                                    arst_n,
    input  wire                                    wr_en,
    input  wire  [seg_display_pkg::DIGIT_W-1:0]    wr_addr,
    input  wire  [seg_display_pkg::CHAR_W-1:0]     wr_char,
    input  wire                                    wr_point,
    input  wire                                    display_en,
    output wire  [seg_display_pkg::SEG_W-1:0]      seg,
    output wire  [seg_display_pkg::NUM_DIGITS-1:0] sel
);

    wire [seg_display_pkg::NUM_DIGITS*seg_display_pkg::CHAR_W-1:0] chars;
    wire [seg_display_pkg::NUM_DIGITS-1:0]                         points;
    wire [seg_display_pkg::NUM_DIGITS*seg_display_pkg::SEG_W-1:0]  patterns;  // active high.

    // host writes land here.
    text_buffer text_buffer_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_char  (wr_char),
        .wr_point (wr_point),
        .chars    (chars),
        .points   (points)
    );

    glyph_decoder glyph_decoder_inst (
        .chars    (chars),
        .points   (points),
        .patterns (patterns)
    );

    // scanning and board polarity.
    scan_mux scan_mux_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .display_en (display_en),
        .patterns   (patterns),
        .seg        (seg),
        .sel        (sel)
    );

endmodule

`default_nettype wire

/* sim/tb_seg_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_seg_display;

    logic                                   clk;
    logic                                   arst_n;
    logic                                   wr_en;
    logic [seg_display_pkg::DIGIT_W-1:0]    wr_addr;
    logic [seg_display_pkg::CHAR_W-1:0]     wr_char;
    logic                                   wr_point;
    logic                                   display_en;
    wire  [seg_display_pkg::SEG_W-1:0]      seg;
    wire  [seg_display_pkg::NUM_DIGITS-1:0] sel;

    // reference copy of the text buffer.
    logic [seg_display_pkg::CHAR_W-1:0]     model_char [seg_display_pkg::NUM_DIGITS];
    logic [seg_display_pkg::NUM_DIGITS-1:0] model_point;

    // expected scan outputs, one edge ahead of sampling.
    int                                     edge_cnt;
    int                                     scan_step;
    logic [seg_display_pkg::DIGIT_W-1:0]    scan_digit;
    logic [seg_display_pkg::NUM_DIGITS-1:0] sel_next;
    logic [seg_display_pkg::NUM_DIGITS-1:0] exp_sel;
    logic [seg_display_pkg::SEG_W-1:0]      exp_seg;

    // length of the current run of one sel value.
    logic [seg_display_pkg::NUM_DIGITS-1:0] prev_sel;
    int                                     run_len;
    logic                                   clean_run;  // run began right after a lit digit.

    logic [31:0]                            lfsr_state;

    seg_display_top seg_display_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_char    (wr_char),
        .wr_point   (wr_point),
        .display_en (display_en),
        .seg        (seg),
        .sel        (sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // segments g..a, lower case folds onto upper case.
    function automatic logic [seg_display_pkg::SEG_W-2:0] expected_glyph(
        input logic [seg_display_pkg::CHAR_W-1:0] c
    );
        logic [seg_display_pkg::CHAR_W-1:0] u;
        u = (c >= "a" && c <= "z") ? c - 8'h20 : c;
        case (u)
            "0": expected_glyph = 7'h3f;
            "1": expected_glyph = 7'h06;
            "2": expected_glyph = 7'h5b;
            "3": expected_glyph = 7'h4f;
            "4": expected_glyph = 7'h66;
            "5": expected_glyph = 7'h6d;
            "6": expected_glyph = 7'h7d;
            "7": expected_glyph = 7'h07;
            "8": expected_glyph = 7'h7f;
            "9": expected_glyph = 7'h6f;
            "A": expected_glyph = 7'h77;
            "B": expected_glyph = 7'h7c;
            "C", "(": expected_glyph = 7'h39;
            "D": expected_glyph = 7'h5e;
            "E": expected_glyph = 7'h79;
            "F": expected_glyph = 7'h71;
            "G": expected_glyph = 7'h3d;
            "H": expected_glyph = 7'h76;
            "I", ")": expected_glyph = 7'h0f;
            "J": expected_glyph = 7'h0e;
            "K": expected_glyph = 7'h75;
            "L": expected_glyph = 7'h38;
            "M": expected_glyph = 7'h37;
            "N": expected_glyph = 7'h54;
            "O", "+": expected_glyph = 7'h5c;
            "P": expected_glyph = 7'h73;
            "Q": expected_glyph = 7'h67;
            "R": expected_glyph = 7'h31;
            "S": expected_glyph = 7'h49;
            "T": expected_glyph = 7'h78;
            "U": expected_glyph = 7'h3e;
            "V": expected_glyph = 7'h1c;
            "W": expected_glyph = 7'h7e;
            "X": expected_glyph = 7'h64;
            "Y": expected_glyph = 7'h6e;
            "Z": expected_glyph = 7'h59;
            "-": expected_glyph = 7'h40;
            "_": expected_glyph = 7'h08;
            "=": expected_glyph = 7'h48;
            default: expected_glyph = 7'h00;  // space and unlisted.
        endcase
    endfunction

    // x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic next_random_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic int random_value(input int nbits);
        int v;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            v = (v << 1) | int'(next_random_bit());
        end
        return v;
    endfunction

    // scan model, digit d lit for DWELL_CYCLES edges from edge 2 on.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            edge_cnt <= 0;
            exp_sel <= '1;
            exp_seg <= '1;
            model_point <= '0;
            for (int d = 0; d < seg_display_pkg::NUM_DIGITS; d++) begin
                model_char[d] <= " ";
            end
        end else begin
            edge_cnt <= edge_cnt + 1;
            if (edge_cnt == 0 || !display_en) begin
                exp_sel <= '1;
                exp_seg <= '1;
            end else begin
                scan_step = ((edge_cnt - 1) / seg_display_pkg::DWELL_CYCLES)
                            % seg_display_pkg::NUM_DIGITS;
                scan_digit = scan_step[seg_display_pkg::DIGIT_W-1:0];
                sel_next = '1;
                sel_next[scan_digit] = 1'b0;
                exp_sel <= sel_next;
                exp_seg <= ~{model_point[scan_digit], expected_glyph(model_char[scan_digit])};
            end
            if (wr_en) begin
                model_char[wr_addr] <= wr_char;
                model_point[wr_addr] <= wr_point;
            end
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_sel <= '1;
            run_len <= 0;
            clean_run <= 1'b0;
        end else begin
            prev_sel <= sel;
            if (sel == prev_sel) begin
                run_len <= run_len + 1;
            end else begin
                run_len <= 1;
                clean_run <= (prev_sel != '1);
            end
        end
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    reset_dark_a: assert property (
        @(posedge clk) !arst_n |-> (seg == '1) && (sel == '1)
    ) else begin
        $display("mismatch at %0t: seg/sel during reset expected ff/ff, actual %h/%h",
                 $time, $sampled(seg), $sampled(sel));
        abort_run();
    end

    one_cold_a: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(~sel)
    ) else begin
        $display("mismatch at %0t: sel expected at most one low bit, actual %b",
                 $time, $sampled(sel));
        abort_run();
    end

    sel_order_a: assert property (
        @(posedge clk) disable iff (!arst_n) sel == exp_sel
    ) else begin
        $display("mismatch at %0t: sel expected %b, actual %b",
                 $time, $sampled(exp_sel), $sampled(sel));
        abort_run();
    end

    seg_glyph_a: assert property (
        @(posedge clk) disable iff (!arst_n) seg == exp_seg
    ) else begin
        $display("mismatch at %0t: seg expected %h, actual %h",
                 $time, $sampled(exp_seg), $sampled(seg));
        abort_run();
    end

    dwell_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (sel != prev_sel) && (sel != '1) && (prev_sel != '1) && clean_run
            |-> run_len == seg_display_pkg::DWELL_CYCLES
    ) else begin
        $display("mismatch at %0t: dwell of sel %b expected %0d, actual %0d",
                 $time, $sampled(prev_sel), seg_display_pkg::DWELL_CYCLES, $sampled(run_len));
        abort_run();
    end

    blank_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$past(display_en) |-> (seg == '1) && (sel == '1)
    ) else begin
        $display("mismatch at %0t: seg/sel while disabled expected ff/ff, actual %h/%h",
                 $time, $sampled(seg), $sampled(sel));
        abort_run();
    end

    // every task starts and ends 1 ns after a rising edge.
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_digit(
        input logic [31:0]                      addr,
        input logic [seg_display_pkg::CHAR_W-1:0] c,
        input logic                             p
    );
        wr_en = 1'b1;
        wr_addr = addr[seg_display_pkg::DIGIT_W-1:0];
        wr_char = c;
        wr_point = p;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic wait_for_digit(input logic [seg_display_pkg::DIGIT_W-1:0] d);
        int n;
        n = 0;
        while (sel[d] !== 1'b0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 2 * seg_display_pkg::NUM_DIGITS * seg_display_pkg::DWELL_CYCLES) begin
                $display("timeout at %0t: digit %0d was never selected", $time, d);
                abort_run();
            end
        end
    endtask

    task automatic wait_until_dark();
        int n;
        n = 0;
        while (sel !== '1 || seg !== '1) begin
            @(posedge clk);
            #1;
            n++;
            if (n > 4) begin
                $display("timeout at %0t: display did not go dark when disabled", $time);
                abort_run();
            end
        end
    endtask

    // one full pass so each digit gets compared.
    task automatic show_all_digits();
        for (int i = 0; i < seg_display_pkg::NUM_DIGITS; i++) begin
            wait_for_digit(i[seg_display_pkg::DIGIT_W-1:0]);
        end
    endtask

    task automatic sweep_table(input string text);
        for (int base = 0; base < text.len(); base += seg_display_pkg::NUM_DIGITS) begin
            for (int d = 0; d < seg_display_pkg::NUM_DIGITS; d++) begin
                if (base + d < text.len()) begin
                    write_digit(d, text[base + d], next_random_bit());
                end
            end
            show_all_digits();
        end
    endtask

    task automatic blank_and_restore(input int dark_cycles);
        display_en = 1'b0;
        wait_until_dark();
        write_digit(5, "8", 1'b1);  // lands while dark.
        step_cycles(dark_cycles);
        display_en = 1'b1;
        show_all_digits();
    endtask

    task automatic rewrite_digits(input string pool, input int count);
        for (int k = 0; k < count; k++) begin
            write_digit(random_value(seg_display_pkg::DIGIT_W),
                        pool[random_value(6) % pool.len()],
                        next_random_bit());
            step_cycles(random_value(3) + 1);
            if (k % seg_display_pkg::NUM_DIGITS == seg_display_pkg::NUM_DIGITS - 1) begin
                show_all_digits();
            end
        end
        show_all_digits();
    endtask

    initial begin
        arst_n = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_char = '0;
        wr_point = 1'b0;
        display_en = 1'b1;
        lfsr_state = 32'h8413;
        #1 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;

        show_all_digits();  // blank text after reset.
        sweep_table("0123456789abcdefghijklmnopqrstuvwxyzABCDEFGHIJKLMNOPQRSTUVWXYZ -_=+()");

        // unlisted codes and a lone point.
        write_digit(2, "?", 1'b0);
        write_digit(3, " ", 1'b1);
        write_digit(4, "#", 1'b1);
        write_digit(6, 8'h7f, 1'b0);
        show_all_digits();

        blank_and_restore(3 * seg_display_pkg::DWELL_CYCLES);
        blank_and_restore(1);

        rewrite_digits("0aZ9 -_=+()?#@!*~.xQmW", 48);
        step_cycles(seg_display_pkg::DWELL_CYCLES);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* seg_display.f */
design/seg_display_pkg.sv
design/text_buffer.sv
design/glyph_decoder.sv
design/scan_mux.sv
design/seg_display_top.sv
sim/tb_seg_display.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# The simulator's exit status reports pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_seg_display \
    -Mdir obj_dir \
    -f seg_display.f

./obj_dir/Vtb_seg_display
